/* design/addr_ctrl_mux.sv */
`default_nettype none
`timescale 1ns/10ps

module addr_ctrl_mux #(
  parameter int N_PORTS = 4                               // Number of input ports, 2 to 4
) (
  input  wire matrix_pkg::port_req_t i_ports [N_PORTS],   // Input port requests
  input  wire matrix_pkg::port_idx_t i_grant,             // Granted port
  input  wire logic                  i_no_port,           // No port granted
  output ahb_pkg::ahb_ctrl_t         o_m_ctrl,            // Address/control to target
  output logic [N_PORTS-1:0]         o_active             // One-hot owner of the target
);

  import matrix_pkg::*;

  // --------------------------------------------------
  // Address and control select
  // --------------------------------------------------
  always_comb
  begin
    o_m_ctrl = '0;                                        // Idle, unselected
    if (!i_no_port)
    begin
      for (int i = 0; i < N_PORTS; i++)
      begin
        if (i_grant == port_idx_t'(i))
        begin
          o_m_ctrl = i_ports[i].ctrl;                     // Whole phase from owner
        end
      end
    end
  end

  // --------------------------------------------------
  // Active decode
  // --------------------------------------------------
  // Tells each input stage that its held transfer is on the target
  always_comb
  begin
    o_active = '0;
    for (int i = 0; i < N_PORTS; i++)
    begin
      o_active[i] = !i_no_port && (i_grant == port_idx_t'(i)); // Same grant as the mux
    end
  end

endmodule

`default_nettype wire

/* design/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W = 32;                     // HADDR width
  localparam int DATA_W = 32;                     // HWDATA width

  // --------------------------------------------------
  // Transfer type
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                               // No transfer
    BUSY   = 2'b01,                               // Burst pause by the master
    NONSEQ = 2'b10,                               // First beat or single
    SEQ    = 2'b11                                // Following burst beat
  } htrans_e;

  // Write data word
  typedef logic [DATA_W-1:0] ahb_data_t;

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------
  typedef struct packed {
    logic              hsel;                      // Target select
    logic [ADDR_W-1:0] haddr;                     // Address
    htrans_e           htrans;                    // Transfer type
    logic              hwrite;                    // Write when high
    logic [2:0]        hsize;                     // Transfer size
    logic [2:0]        hburst;                    // Burst type
    logic [3:0]        hprot;                     // Protection control
    logic [3:0]        hmaster;                   // Master ID
    logic              hmastlock;                 // Locked sequence
  } ahb_ctrl_t;

endpackage

`default_nettype wire

/* design/burst_arbiter.sv */
`default_nettype none
`timescale 1ns/10ps

module burst_arbiter #(
  parameter int N_PORTS = 4                               // Number of input ports, 2 to 4
) (
  input  wire logic                  HCLK,                // Bus clock
  input  wire logic                  HRESETn,             // Sync reset, active low
  input  wire matrix_pkg::port_req_t i_ports [N_PORTS],   // Input port requests
  input  wire ahb_pkg::ahb_ctrl_t    i_m_ctrl,            // Currently routed address phase
  input  wire logic                  i_hreadymux,         // Phase completes when high
  output matrix_pkg::port_idx_t      o_grant,             // Granted port
  output logic                       o_no_port            // No port granted
);

  import ahb_pkg::*;
  import matrix_pkg::*;

  logic [N_PORTS-1:0] req;                                // Qualified requests
  logic               hsel_lock;                          // Lock survives deselect
  logic               next_hsel_lock;                     // Lock flag next value
  logic               hlock_arb;                          // Lock as seen by arbitration
  logic               burst_hold;                         // Burst in progress
  logic               hold;                               // Keep current grant
  port_idx_t          next_grant;                         // Priority winner
  logic               next_no_port;                       // Nobody requesting

  // --------------------------------------------------
  // Request qualification
  // --------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < N_PORTS; i++)
    begin
      req[i] = i_ports[i].held_tran & i_ports[i].ctrl.hsel; // Held and aimed at us
    end
  end

  // --------------------------------------------------
  // Lock tracking
  // --------------------------------------------------
  // A master may address another target in the middle of a locked
  // sequence. The flag remembers that the sequence started here, so
  // the lock is honoured while hsel is low.
  always_comb
  begin
    if (i_m_ctrl.hsel && (i_m_ctrl.htrans inside {NONSEQ, SEQ}) && i_m_ctrl.hmastlock)
    begin
      next_hsel_lock = 1'b1;                              // Locked beat on this target
    end
    else if (!i_m_ctrl.hmastlock)
    begin
      next_hsel_lock = 1'b0;                              // Sequence over
    end
    else
    begin
      next_hsel_lock = hsel_lock;                         // Deselected, still locked
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hsel_lock <= 1'b0;
    end
    else if (i_hreadymux)                                 // Only on completing edges
    begin
      hsel_lock <= next_hsel_lock;
    end
  end

  // Lock masked when not selected, unless the sequence began here
  assign hlock_arb = i_m_ctrl.hmastlock & (i_m_ctrl.hsel | hsel_lock);

  // --------------------------------------------------
  // Hold rule
  // --------------------------------------------------
  assign burst_hold = i_m_ctrl.hsel & (i_m_ctrl.htrans inside {BUSY, SEQ});
  assign hold       = burst_hold | hlock_arb;             // Burst or locked sequence

  // --------------------------------------------------
  // Fixed priority, port 0 highest
  // --------------------------------------------------
  always_comb
  begin
    next_grant   = o_grant;                               // Park on last owner
    next_no_port = 1'b1;
    for (int i = N_PORTS - 1; i >= 0; i--)
    begin
      if (req[i])
      begin
        next_grant   = port_idx_t'(i);                    // Lower index overrides
        next_no_port = 1'b0;
      end
    end
    if (hold)
    begin
      next_grant   = o_grant;                             // Current owner keeps the bus
      next_no_port = o_no_port;
    end
  end

  // Grant register
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_grant   <= '0;
      o_no_port <= 1'b1;                                  // Nobody owns the target
    end
    else if (i_hreadymux)                                 // Frozen during wait states
    begin
      o_grant   <= next_grant;
      o_no_port <= next_no_port;
    end
  end

endmodule

`default_nettype wire

/* design/data_phase_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module data_phase_ctrl #(
  parameter int N_PORTS = 4                               // Number of input ports, 2 to 4
) (
  input  wire logic                  HCLK,                // Bus clock
  input  wire logic                  HRESETn,             // Sync reset, active low
  input  wire matrix_pkg::port_req_t i_ports [N_PORTS],   // Input port requests
  input  wire matrix_pkg::port_idx_t i_grant,             // Owner of the address phase
  input  wire ahb_pkg::ahb_ctrl_t    i_m_ctrl,            // Routed address phase
  input  wire logic                  i_hreadyout,         // Ready from the target
  output ahb_pkg::ahb_data_t         o_hwdata,            // Write data to target
  output logic                       o_hreadymux          // Phase completes when high
);

  import ahb_pkg::*;
  import matrix_pkg::*;

  port_idx_t data_port;                                   // Owner of the data phase
  logic      wdata_phase;                                 // Data phase carries a beat
  logic      slave_sel;                                   // Target was addressed

  // --------------------------------------------------
  // Address to data phase pipeline
  // --------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port   <= '0;
      wdata_phase <= 1'b0;
      slave_sel   <= 1'b0;                                // Ready driven high after reset
    end
    else if (o_hreadymux)                                 // Advance on completing edge
    begin
      data_port   <= i_grant;
      wdata_phase <= i_m_ctrl.hsel & (i_m_ctrl.htrans inside {NONSEQ, SEQ});
      slave_sel   <= i_m_ctrl.hsel;
    end
  end

  // --------------------------------------------------
  // Write data mux
  // --------------------------------------------------
  always_comb
  begin
    o_hwdata = '0;                                        // Quiet bus outside data beats
    if (wdata_phase)
    begin
      for (int i = 0; i < N_PORTS; i++)
      begin
        if (data_port == port_idx_t'(i))
        begin
          o_hwdata = i_ports[i].wdata;
        end
      end
    end
  end

  // Target ready only matters when the target owns the data phase
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

`default_nettype wire

/* design/matrix_pkg.sv */
`default_nettype none

package matrix_pkg;

  // --------------------------------------------------
  // Port numbering
  // --------------------------------------------------
  localparam int PORT_IDX_W = 2;                  // Enough for up to 4 ports

  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // --------------------------------------------------
  // One input port as seen by the output stage
  // --------------------------------------------------
  typedef struct packed {
    ahb_pkg::ahb_ctrl_t ctrl;                     // Held address phase
    ahb_pkg::ahb_data_t wdata;                    // Write data of the port
    logic               held_tran;                // Transfer held in input stage
  } port_req_t;

endpackage

`default_nettype wire

/* design/output_stage_top.sv */
`default_nettype none
`timescale 1ns/10ps

module output_stage_top #(
  parameter int N_PORTS = 4                               // Number of input ports, 2 to 4
) (
  input  wire logic                  HCLK,                // Bus clock
  input  wire logic                  HRESETn,             // Sync reset, active low
  input  wire matrix_pkg::port_req_t i_ports [N_PORTS],   // From the input stages
  input  wire logic                  i_hreadyout,         // Ready from the target
  output ahb_pkg::ahb_ctrl_t         o_m_ctrl,            // Address/control to target
  output ahb_pkg::ahb_data_t         o_hwdata,            // Write data to target
  output logic                       o_hreadymux,         // Ready back to the matrix
  output logic [N_PORTS-1:0]         o_active             // Per-port active flags
);

  import matrix_pkg::*;

  port_idx_t grant;                                       // Registered owner
  logic      no_port;                                     // Target unowned

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------
  burst_arbiter #(
    .N_PORTS     (N_PORTS)
  ) u_burst_arbiter (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_ports     (i_ports),
    .i_m_ctrl    (o_m_ctrl),                              // Hold rule looks at routed phase
    .i_hreadymux (o_hreadymux),
    .o_grant     (grant),
    .o_no_port   (no_port)
  );

  // --------------------------------------------------
  // Address phase routing
  // --------------------------------------------------
  addr_ctrl_mux #(
    .N_PORTS     (N_PORTS)
  ) u_addr_ctrl_mux (
    .i_ports     (i_ports),
    .i_grant     (grant),
    .i_no_port   (no_port),
    .o_m_ctrl    (o_m_ctrl),
    .o_active    (o_active)
  );

  // --------------------------------------------------
  // Data phase and ready
  // --------------------------------------------------
  data_phase_ctrl #(
    .N_PORTS     (N_PORTS)
  ) u_data_phase_ctrl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_ports     (i_ports),
    .i_grant     (grant),                                 // Becomes data owner on completion
    .i_m_ctrl    (o_m_ctrl),
    .i_hreadyout (i_hreadyout),
    .o_hwdata    (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

endmodule

`default_nettype wire

/* dv/output_stage_sva.sv */
`default_nettype none
`timescale 1ns/10ps

module output_stage_sva #(
  parameter int N_PORTS = 4                               // Matches the bound instance
) (
  input wire logic                  HCLK,                 // Bus clock
  input wire logic                  HRESETn,              // Sync reset, active low
  input wire ahb_pkg::ahb_ctrl_t    i_m_ctrl,             // Routed address phase
  input wire matrix_pkg::port_idx_t i_grant,              // Registered owner
  input wire logic                  i_no_port,            // Target unowned
  input wire logic                  i_hreadymux,          // Phase completes when high
  input wire logic [N_PORTS-1:0]    i_active              // Per-port active flags
);

  int fail_cnt = 0;                                       // Failed assertions so far

  // At most one input stage owns the target
  a_active_onehot : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(i_active))
    else
    begin
      fail_cnt++;
      $error("o_active has more than one bit set");
    end

  // Wait state freezes arbitration
  a_grant_stable : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> $stable({i_grant, i_no_port}))
    else
    begin
      fail_cnt++;
      $error("grant changed during a wait state");
    end

  // Unselected phase leaves nothing to wait for
  a_ready_unsel : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (i_hreadymux && !i_m_ctrl.hsel) |=> i_hreadymux)
    else
    begin
      fail_cnt++;
      $error("hreadymux low after an unselected phase");
    end

endmodule

bind output_stage_top output_stage_sva #(
  .N_PORTS     (N_PORTS)
) u_output_stage_sva (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .i_m_ctrl    (o_m_ctrl),
  .i_grant     (grant),
  .i_no_port   (no_port),
  .i_hreadymux (o_hreadymux),
  .i_active    (o_active)
);

`default_nettype wire

/* dv/output_stage_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module output_stage_tb;

  import ahb_pkg::*;
  import matrix_pkg::*;

  localparam int N_PORTS       = 4;                       // Full matrix width
  localparam int CLK_PERIOD_NS = 40;
  localparam int N_TESTS       = 6;                       // Budget, not the exact count
  localparam int TEST_CYCLES   = 40;                      // Generous per test
  localparam int WATCHDOG_NS   = N_TESTS * TEST_CYCLES * CLK_PERIOD_NS;

  logic               hclk;
  logic               hresetn;
  port_req_t          ports [N_PORTS];                    // Input stage side
  logic               hreadyout;                          // Target ready
  ahb_ctrl_t          m_ctrl;
  ahb_data_t          hwdata;
  logic               hreadymux;
  logic [N_PORTS-1:0] active;
  string              test_name;                          // Shown in error lines

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (2)
  ) u_clk_gen (
    .o_hclk       (hclk),
    .o_hresetn    (hresetn)
  );

  output_stage_top #(
    .N_PORTS     (N_PORTS)
  ) dut0 (
    .HCLK        (hclk),
    .HRESETn     (hresetn),
    .i_ports     (ports),
    .i_hreadyout (hreadyout),
    .o_m_ctrl    (m_ctrl),
    .o_hwdata    (hwdata),
    .o_hreadymux (hreadymux),
    .o_active    (active)
  );

  // --------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_ctrl(input string what, input ahb_ctrl_t exp, input ahb_ctrl_t act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s %s expected %h actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_data(input string what, input ahb_data_t exp, input ahb_data_t act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s %s expected %h actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_active(input string what, input logic [N_PORTS-1:0] exp,
                              input logic [N_PORTS-1:0] act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s %s expected %b actual %b",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s %s expected %b actual %b",
                              test_name, what, exp, act));
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic ahb_ctrl_t make_ctrl(input logic sel, input htrans_e trans,
                                          input logic write, input logic lock,
                                          input logic [3:0] master);
    ahb_ctrl_t c;
    c           = '0;
    c.hsel      = sel;
    c.haddr     = $urandom;                               // Any address will do
    c.htrans    = trans;
    c.hwrite    = write;
    c.hsize     = 3'b010;                                 // Word
    c.hburst    = 3'b001;                                 // INCR
    c.hprot     = 4'b0011;
    c.hmaster   = master;
    c.hmastlock = lock;
    return c;
  endfunction

  function automatic port_req_t make_req(input ahb_ctrl_t ctrl);
    port_req_t r;
    r.ctrl      = ctrl;
    r.wdata     = $urandom;
    r.held_tran = 1'b1;                                   // Transfer waiting in input stage
    return r;
  endfunction

  // Sample point and drive point in one
  task automatic step();
    @(negedge hclk);
  endtask

  task automatic idle_all();
    for (int i = 0; i < N_PORTS; i++)
    begin
      ports[i] = '0;
    end
    hreadyout = 1'b1;
    repeat (3) step();
    check_active("active when idle", '0, active);        // Target released
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset();
    test_name = "reset";
    check_ctrl("m_ctrl", '0, m_ctrl);
    check_active("active", '0, active);
    check_bit("hreadymux", 1'b1, hreadymux);
    check_data("hwdata", '0, hwdata);
  endtask

  task automatic test_single_route();
    test_name = "single_route";
    ports[2] = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd2));
    check_ctrl("m_ctrl before grant", '0, m_ctrl);       // Grant is registered
    step();
    check_ctrl("m_ctrl", ports[2].ctrl, m_ctrl);
    check_active("active", 4'b0100, active);
    idle_all();
  endtask

  task automatic test_priority_burst();
    test_name = "priority_burst";
    ports[1] = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd1));
    ports[3] = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd3));
    step();
    check_active("port 1 over port 3", 4'b0010, active);
    check_ctrl("m_ctrl of port 1", ports[1].ctrl, m_ctrl);
    step();                                               // First beat completes
    check_active("after first beat", 4'b0010, active);
    ports[1].ctrl.htrans = SEQ;
    ports[0] = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd0));
    repeat (3)
    begin
      step();
      check_active("burst hold", 4'b0010, active);      // Port 0 must wait
    end
    ports[1] = '0;                                        // Burst done, port 1 idle
    step();
    check_active("port 0 after idle", 4'b0001, active);
    check_ctrl("m_ctrl of port 0", ports[0].ctrl, m_ctrl);
    idle_all();
  endtask

  task automatic test_lock_deselect();
    test_name = "lock_deselect";
    ports[3] = make_req(make_ctrl(1'b1, NONSEQ, 1'b1, 1'b1, 4'd3));
    step();
    check_active("port 3 granted", 4'b1000, active);
    ports[0] = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd0));
    step();                                               // Locked beat completes
    check_active("locked beat", 4'b1000, active);
    ports[3].ctrl.hsel = 1'b0;                            // Off to another target
    repeat (3)
    begin
      step();
      check_active("lock across deselect", 4'b1000, active);
      check_bit("hreadymux deselected", 1'b1, hreadymux);
    end
    ports[3] = '0;                                        // hmastlock dropped
    step();
    check_active("port 0 after unlock", 4'b0001, active);
    idle_all();
  endtask

  task automatic test_write_wait();
    test_name = "write_wait";
    ports[1] = make_req(make_ctrl(1'b1, NONSEQ, 1'b1, 1'b0, 4'd1));
    step();
    check_active("port 1 granted", 4'b0010, active);
    step();                                               // Write address phase done
    check_data("hwdata of port 1", ports[1].wdata, hwdata);
    check_bit("hreadymux follows target", hreadyout, hreadymux);
    ports[1].ctrl.htrans = IDLE;                          // Still selected, no beat
    ports[1].held_tran   = 1'b0;
    ports[0]  = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd0));
    ports[2]  = make_req(make_ctrl(1'b1, NONSEQ, 1'b0, 1'b0, 4'd2));
    hreadyout = 1'b0;                                     // Target inserts wait states
    repeat (3)
    begin
      step();
      check_bit("hreadymux in wait", 1'b0, hreadymux);
      check_active("grant frozen", 4'b0010, active);
      check_data("hwdata held", ports[1].wdata, hwdata);
    end
    hreadyout = 1'b1;
    step();                                               // IDLE phase completes
    check_data("hwdata after idle", '0, hwdata);
    check_bit("hreadymux after idle", 1'b1, hreadymux);
    check_active("port 0 after wait", 4'b0001, active);
    idle_all();
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial
  begin
    void'($urandom(32'h8300_1d48));
    test_name = "none";
    hreadyout = 1'b1;
    for (int i = 0; i < N_PORTS; i++)
    begin
      ports[i] = '0;                                      // No requests during reset
    end
    wait (hresetn === 1'b1);
    test_reset();
    test_single_route();
    test_priority_burst();
    test_lock_deselect();
    test_write_wait();
    if (dut0.u_output_stage_sva.fail_cnt == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      stop_on_error("Assertion failed in the bound checker");
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,                        // HCLK period
  parameter int RESET_CYCLES = 2                          // Rising edges with reset low
) (
  output logic o_hclk,                                    // Bus clock
  output logic o_hresetn                                  // Sync reset, active low
);

  // Free running clock, low for the first half period
  initial
  begin
    o_hclk = 1'b0;
    forever #(PERIOD_NS / 2) o_hclk = ~o_hclk;
  end

  initial
  begin
    o_hresetn = 1'b0;                                     // Reset from time zero
    repeat (RESET_CYCLES) @(posedge o_hclk);
    @(negedge o_hclk);                                    // Release with the stimulus
    o_hresetn = 1'b1;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the output stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module output_stage_tb \
  -f tb.f

out=$(./obj_dir/Voutput_stage_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi

/* tb.f */
design/ahb_pkg.sv
design/matrix_pkg.sv
design/burst_arbiter.sv
design/addr_ctrl_mux.sv
design/data_phase_ctrl.sv
design/output_stage_top.sv
dv/output_stage_sva.sv
dv/tb_clk_gen.sv
dv/output_stage_tb.sv
